// ==== logic/cpuIsaPkg.sv ====
package cpuIsaPkg;

	localparam logic [3:0] opRegister = 4'b0000;
	localparam logic [3:0] opMemory   = 4'b0100;
	localparam logic [3:0] opShift    = 4'b1000;
	localparam logic [3:0] opBranch   = 4'b1100;
	localparam logic [3:0] opAddi     = 4'b0101;
	localparam logic [3:0] opAddui    = 4'b0110; // the only zero-extended immediate.
	localparam logic [3:0] opMuli     = 4'b1110;
	localparam logic [3:0] opSubi     = 4'b1001;
	localparam logic [3:0] opCmpi     = 4'b1011;
	localparam logic [3:0] opAndi     = 4'b0001;
	localparam logic [3:0] opOri      = 4'b0010;
	localparam logic [3:0] opXori     = 4'b0011;

	localparam logic [3:0] extAdd   = 4'b0101;
	localparam logic [3:0] extSub   = 4'b1001;
	localparam logic [3:0] extCmp   = 4'b1011;
	localparam logic [3:0] extAnd   = 4'b0001;
	localparam logic [3:0] extOr    = 4'b0010;
	localparam logic [3:0] extXor   = 4'b0011;
	localparam logic [3:0] extMul   = 4'b1110;
	localparam logic [3:0] extLsh   = 4'b0100;
	localparam logic [3:0] extLoad  = 4'b0000;
	localparam logic [3:0] extStore = 4'b0100;
	localparam logic [3:0] extJcond = 4'b1100;
	localparam logic [3:0] extScond = 4'b1101;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluCmp,
		aluAnd,
		aluOr,
		aluXor,
		aluLsh,
		aluMul
	} aluOpT;

	localparam int flagC = 0;
	localparam int flagL = 1;
	localparam int flagF = 2;
	localparam int flagZ = 3;
	localparam int flagN = 4;

	localparam logic [3:0] condZ      = 4'b0000;
	localparam logic [3:0] condNotZ   = 4'b0001;
	localparam logic [3:0] condC      = 4'b0010;
	localparam logic [3:0] condNotC   = 4'b0011;
	localparam logic [3:0] condL      = 4'b0100;
	localparam logic [3:0] condNotL   = 4'b0101;
	localparam logic [3:0] condN      = 4'b0110;
	localparam logic [3:0] condNotN   = 4'b0111;
	localparam logic [3:0] condF      = 4'b1000;
	localparam logic [3:0] condNotF   = 4'b1001;
	localparam logic [3:0] condNoLZ   = 4'b1010; // neither L nor Z.
	localparam logic [3:0] condLOrZ   = 4'b1011;
	localparam logic [3:0] condNoNZ   = 4'b1100; // neither N nor Z.
	localparam logic [3:0] condNOrZ   = 4'b1101;
	localparam logic [3:0] condAlways = 4'b1110;
	localparam logic [3:0] condNever  = 4'b1111;

endpackage

// ==== logic/cpuCtrlPkg.sv ====
package cpuCtrlPkg;

	typedef enum logic [3:0] {
		fetch,
		decode,
		operand,
		execute,
		memAddr,
		memWait,
		loadWrite,
		storeWrite,
		setCond,
		resolve
	} ctrlStateT;

	typedef enum logic [1:0] {
		aluResult,
		memData,
		condBit
	} writeSelT;

	typedef enum logic [1:0] {
		hold,
		step,
		branch,
		jump
	} pcActionT;

endpackage

// ==== logic/aluUnit.sv ====
`timescale 1ns/1ps

module aluUnit (
	input logic [15:0] a,
	input logic [15:0] b,
	input cpuIsaPkg::aluOpT op,
	output logic [15:0] result,
	output logic [4:0] flags
);

	logic [16:0] sum;
	logic [16:0] diff;

	assign sum = {1'b0, a} + {1'b0, b};
	assign diff = {1'b0, a} - {1'b0, b}; // bit 16 is the borrow.

	always_comb begin
		result = '0;
		flags = '0;
		case (op)
			cpuIsaPkg::aluAdd: begin
				result = sum[15:0];
				flags[cpuIsaPkg::flagC] = sum[16];
				flags[cpuIsaPkg::flagF] = (a[15] == b[15]) && (sum[15] != a[15]);
			end
			cpuIsaPkg::aluSub: begin
				result = diff[15:0];
				flags[cpuIsaPkg::flagC] = diff[16];
				flags[cpuIsaPkg::flagF] = (a[15] != b[15]) && (diff[15] != a[15]);
			end
			cpuIsaPkg::aluCmp: result = diff[15:0];
			cpuIsaPkg::aluAnd: result = a & b;
			cpuIsaPkg::aluOr: result = a | b;
			cpuIsaPkg::aluXor: result = a ^ b;
			cpuIsaPkg::aluLsh: result = a << b[3:0];
			cpuIsaPkg::aluMul: result = a * b; // only the low half is kept.
			default: result = '0;
		endcase

		if (op == cpuIsaPkg::aluCmp) begin
			flags[cpuIsaPkg::flagZ] = (a == b);
			flags[cpuIsaPkg::flagN] = ($signed(a) < $signed(b));
			flags[cpuIsaPkg::flagL] = (a < b);
		end else begin
			flags[cpuIsaPkg::flagZ] = (result == 16'h0000);
			flags[cpuIsaPkg::flagN] = result[15];
		end
	end

endmodule

// ==== logic/registerFile.sv ====
`timescale 1ns/1ps

module registerFile (
	input logic Clk,
	input logic reset,
	input logic [3:0] srcSel,
	input logic [3:0] destSel,
	input logic writeEnable,
	input logic [15:0] writeData,
	output logic [15:0] srcData,
	output logic [15:0] destData
);

	logic [15:0] regs [16];

	always_ff @(posedge Clk) begin
		if (reset) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
		end else if (writeEnable) begin
			regs[destSel] <= writeData;
		end
	end

	// both reads are asynchronous so operands settle within the state.
	assign srcData = regs[srcSel];
	assign destData = regs[destSel];

endmodule

// ==== logic/programCounter.sv ====
`timescale 1ns/1ps

module programCounter #(
	parameter logic [15:0] resetAddr = 16'h0000
) (
	input logic Clk,
	input logic reset,
	input cpuCtrlPkg::pcActionT action,
	input logic [7:0] disp,
	input logic [15:0] jumpTarget,
	output logic [15:0] pc
);

	logic [15:0] dispExt;

	assign dispExt = {{8{disp[7]}}, disp};

	always_ff @(posedge Clk) begin
		if (reset) begin
			pc <= resetAddr;
		end else begin
			case (action)
				cpuCtrlPkg::step: pc <= pc + 16'd1;
				cpuCtrlPkg::branch: pc <= pc + dispExt; // relative to the branch itself.
				cpuCtrlPkg::jump: pc <= jumpTarget;
				default: pc <= pc;
			endcase
		end
	end

endmodule

// ==== logic/controlFsm.sv ====
`timescale 1ns/1ps

module controlFsm (
	input logic Clk,
	input logic reset,
	input logic [15:0] instr,
	input logic [4:0] aluFlags,
	output logic instrFetch,
	output logic [3:0] regSrc,
	output logic [3:0] regDest,
	output cpuIsaPkg::aluOpT aluOp,
	output logic useImm,
	output logic immSigned,
	output logic [7:0] imm,
	output logic regWrite,
	output cpuCtrlPkg::writeSelT writeSel,
	output logic condBit,
	output cpuCtrlPkg::pcActionT pcAction,
	output logic dataRead,
	output logic dataWrite
);

	cpuCtrlPkg::ctrlStateT state;
	cpuCtrlPkg::ctrlStateT nextState;
	logic [15:0] instrReg;
	logic [4:0] flagReg;
	logic [3:0] condSel;

	// first state after decode for a freshly fetched word; fetch means unknown.
	function automatic cpuCtrlPkg::ctrlStateT classState(input logic [15:0] word);
		cpuCtrlPkg::ctrlStateT target;
		target = cpuCtrlPkg::fetch;
		case (word[15:12])
			cpuIsaPkg::opRegister: begin
				case (word[7:4])
					cpuIsaPkg::extAdd, cpuIsaPkg::extSub, cpuIsaPkg::extCmp,
					cpuIsaPkg::extAnd, cpuIsaPkg::extOr, cpuIsaPkg::extXor,
					cpuIsaPkg::extMul: target = cpuCtrlPkg::operand;
					default: target = cpuCtrlPkg::fetch;
				endcase
			end
			cpuIsaPkg::opShift: begin
				if (word[7:4] == cpuIsaPkg::extLsh)
					target = cpuCtrlPkg::operand;
			end
			cpuIsaPkg::opMemory: begin
				case (word[7:4])
					cpuIsaPkg::extLoad, cpuIsaPkg::extStore: target = cpuCtrlPkg::memAddr;
					cpuIsaPkg::extScond: target = cpuCtrlPkg::setCond;
					cpuIsaPkg::extJcond: target = cpuCtrlPkg::resolve;
					default: target = cpuCtrlPkg::fetch;
				endcase
			end
			cpuIsaPkg::opBranch: target = cpuCtrlPkg::resolve;
			cpuIsaPkg::opAddi, cpuIsaPkg::opAddui, cpuIsaPkg::opMuli, cpuIsaPkg::opSubi,
			cpuIsaPkg::opCmpi, cpuIsaPkg::opAndi, cpuIsaPkg::opOri,
			cpuIsaPkg::opXori: target = cpuCtrlPkg::operand;
			default: target = cpuCtrlPkg::fetch;
		endcase
		return target;
	endfunction

	function automatic cpuIsaPkg::aluOpT opFor(input logic [15:0] word);
		cpuIsaPkg::aluOpT op;
		op = cpuIsaPkg::aluAdd; // ADD, ADDI and ADDUI fall through to this.
		case (word[15:12])
			cpuIsaPkg::opRegister: begin
				case (word[7:4])
					cpuIsaPkg::extSub: op = cpuIsaPkg::aluSub;
					cpuIsaPkg::extCmp: op = cpuIsaPkg::aluCmp;
					cpuIsaPkg::extAnd: op = cpuIsaPkg::aluAnd;
					cpuIsaPkg::extOr: op = cpuIsaPkg::aluOr;
					cpuIsaPkg::extXor: op = cpuIsaPkg::aluXor;
					cpuIsaPkg::extMul: op = cpuIsaPkg::aluMul;
					default: op = cpuIsaPkg::aluAdd;
				endcase
			end
			cpuIsaPkg::opShift: op = cpuIsaPkg::aluLsh;
			cpuIsaPkg::opMuli: op = cpuIsaPkg::aluMul;
			cpuIsaPkg::opSubi: op = cpuIsaPkg::aluSub;
			cpuIsaPkg::opCmpi: op = cpuIsaPkg::aluCmp;
			cpuIsaPkg::opAndi: op = cpuIsaPkg::aluAnd;
			cpuIsaPkg::opOri: op = cpuIsaPkg::aluOr;
			cpuIsaPkg::opXori: op = cpuIsaPkg::aluXor;
			default: op = cpuIsaPkg::aluAdd;
		endcase
		return op;
	endfunction

	function automatic logic condHolds(input logic [3:0] cond, input logic [4:0] f);
		logic holds;
		holds = 1'b0;
		case (cond)
			cpuIsaPkg::condZ: holds = f[cpuIsaPkg::flagZ];
			cpuIsaPkg::condNotZ: holds = !f[cpuIsaPkg::flagZ];
			cpuIsaPkg::condC: holds = f[cpuIsaPkg::flagC];
			cpuIsaPkg::condNotC: holds = !f[cpuIsaPkg::flagC];
			cpuIsaPkg::condL: holds = f[cpuIsaPkg::flagL];
			cpuIsaPkg::condNotL: holds = !f[cpuIsaPkg::flagL];
			cpuIsaPkg::condN: holds = f[cpuIsaPkg::flagN];
			cpuIsaPkg::condNotN: holds = !f[cpuIsaPkg::flagN];
			cpuIsaPkg::condF: holds = f[cpuIsaPkg::flagF];
			cpuIsaPkg::condNotF: holds = !f[cpuIsaPkg::flagF];
			cpuIsaPkg::condNoLZ: holds = !(f[cpuIsaPkg::flagL] || f[cpuIsaPkg::flagZ]);
			cpuIsaPkg::condLOrZ: holds = f[cpuIsaPkg::flagL] || f[cpuIsaPkg::flagZ];
			cpuIsaPkg::condNoNZ: holds = !(f[cpuIsaPkg::flagN] || f[cpuIsaPkg::flagZ]);
			cpuIsaPkg::condNOrZ: holds = f[cpuIsaPkg::flagN] || f[cpuIsaPkg::flagZ];
			cpuIsaPkg::condAlways: holds = 1'b1;
			cpuIsaPkg::condNever: holds = 1'b0;
			default: holds = 1'b0;
		endcase
		return holds;
	endfunction

	always_ff @(posedge Clk) begin
		if (reset) begin
			state <= cpuCtrlPkg::fetch;
			instrReg <= '0;
			flagReg <= '0;
		end else begin
			state <= nextState;
			if (state == cpuCtrlPkg::decode)
				instrReg <= instr; // the word arrives one cycle after the fetch pulse.
			if (state == cpuCtrlPkg::execute)
				flagReg <= aluFlags; // every ALU operation rewrites all five flags.
		end
	end

	always_comb begin
		nextState = cpuCtrlPkg::fetch;
		pcAction = cpuCtrlPkg::hold;
		regWrite = 1'b0;
		writeSel = cpuCtrlPkg::aluResult;
		dataRead = 1'b0;
		dataWrite = 1'b0;
		case (state)
			cpuCtrlPkg::fetch: nextState = cpuCtrlPkg::decode;
			cpuCtrlPkg::decode: begin
				nextState = classState(instr);
				if (nextState == cpuCtrlPkg::fetch)
					pcAction = cpuCtrlPkg::step; // unknown words are skipped here.
			end
			cpuCtrlPkg::operand: nextState = cpuCtrlPkg::execute;
			cpuCtrlPkg::execute: begin
				regWrite = (aluOp != cpuIsaPkg::aluCmp);
				pcAction = cpuCtrlPkg::step;
			end
			cpuCtrlPkg::memAddr: begin
				if (instrReg[7:4] == cpuIsaPkg::extLoad) begin
					dataRead = 1'b1;
					nextState = cpuCtrlPkg::memWait;
				end else begin
					nextState = cpuCtrlPkg::storeWrite;
				end
			end
			cpuCtrlPkg::memWait: nextState = cpuCtrlPkg::loadWrite;
			cpuCtrlPkg::loadWrite: begin
				regWrite = 1'b1;
				writeSel = cpuCtrlPkg::memData;
				pcAction = cpuCtrlPkg::step;
			end
			cpuCtrlPkg::storeWrite: begin
				dataWrite = 1'b1;
				pcAction = cpuCtrlPkg::step;
			end
			cpuCtrlPkg::setCond: begin
				regWrite = 1'b1;
				writeSel = cpuCtrlPkg::condBit;
				pcAction = cpuCtrlPkg::step;
			end
			cpuCtrlPkg::resolve: begin
				if (!condBit)
					pcAction = cpuCtrlPkg::step;
				else if (instrReg[15:12] == cpuIsaPkg::opBranch)
					pcAction = cpuCtrlPkg::branch;
				else
					pcAction = cpuCtrlPkg::jump;
			end
			default: nextState = cpuCtrlPkg::fetch;
		endcase
	end

	// Scond keeps its condition in the low nibble, branches and jumps in bits 11:8.
	assign condSel = (instrReg[15:12] == cpuIsaPkg::opMemory
		&& instrReg[7:4] == cpuIsaPkg::extScond) ? instrReg[3:0] : instrReg[11:8];
	assign condBit = condHolds(condSel, flagReg);

	assign instrFetch = (state == cpuCtrlPkg::fetch) && !reset; // quiet while held in reset.
	assign regSrc = instrReg[3:0];
	assign regDest = instrReg[11:8];
	assign aluOp = opFor(instrReg);
	assign useImm = !(instrReg[15:12] == cpuIsaPkg::opRegister
		|| instrReg[15:12] == cpuIsaPkg::opShift);
	assign immSigned = (instrReg[15:12] != cpuIsaPkg::opAddui);
	assign imm = instrReg[7:0]; // doubles as the branch displacement.

endmodule

// ==== logic/cpuCore.sv ====
`timescale 1ns/1ps

module cpuCore #(
	parameter logic [15:0] resetAddr = 16'h0000
) (
	input logic Clk,
	input logic reset,
	input logic [15:0] instr,
	input logic [15:0] dataRdata,
	output logic instrFetch,
	output logic [15:0] instrAddr,
	output logic dataRead,
	output logic dataWrite,
	output logic [15:0] dataAddr,
	output logic [15:0] dataWdata,
	output logic commitValid,
	output logic [3:0] commitReg,
	output logic [15:0] commitData
);

	logic [3:0] regSrc;
	logic [3:0] regDest;
	cpuIsaPkg::aluOpT aluOp;
	logic useImm;
	logic immSigned;
	logic [7:0] imm;
	logic regWrite;
	cpuCtrlPkg::writeSelT writeSel;
	logic condBit;
	cpuCtrlPkg::pcActionT pcAction;
	logic [4:0] aluFlags;
	logic [15:0] srcData;
	logic [15:0] destData;
	logic [15:0] immExt;
	logic [15:0] aluB;
	logic [15:0] aluOut;
	logic [15:0] writeData;

	controlFsm ctrl (
		.Clk(Clk),
		.reset(reset),
		.instr(instr),
		.aluFlags(aluFlags),
		.instrFetch(instrFetch),
		.regSrc(regSrc),
		.regDest(regDest),
		.aluOp(aluOp),
		.useImm(useImm),
		.immSigned(immSigned),
		.imm(imm),
		.regWrite(regWrite),
		.writeSel(writeSel),
		.condBit(condBit),
		.pcAction(pcAction),
		.dataRead(dataRead),
		.dataWrite(dataWrite)
	);

	assign immExt = immSigned ? {{8{imm[7]}}, imm} : {8'h00, imm};
	assign aluB = useImm ? immExt : srcData;

	aluUnit alu (
		.a(destData),
		.b(aluB),
		.op(aluOp),
		.result(aluOut),
		.flags(aluFlags)
	);

	registerFile regs (
		.Clk(Clk),
		.reset(reset),
		.srcSel(regSrc),
		.destSel(regDest),
		.writeEnable(regWrite),
		.writeData(writeData),
		.srcData(srcData),
		.destData(destData)
	);

	programCounter #(
		.resetAddr(resetAddr)
	) pcUnit (
		.Clk(Clk),
		.reset(reset),
		.action(pcAction),
		.disp(imm),
		.jumpTarget(srcData),
		.pc(instrAddr)
	);

	always_comb begin
		case (writeSel)
			cpuCtrlPkg::memData: writeData = dataRdata; // read word is still held in loadWrite.
			cpuCtrlPkg::condBit: writeData = {15'h0000, condBit};
			default: writeData = aluOut;
		endcase
	end

	assign dataAddr = srcData;
	assign dataWdata = destData;
	assign commitValid = regWrite;
	assign commitReg = regDest;
	assign commitData = writeData;

endmodule

// ==== sim/clockGen.sv ====
`timescale 1ns/1ps

module clockGen #(
	parameter int resetCycles = 5
) (
	output logic Clk,
	output logic reset
);

	initial begin
		Clk = 1'b0;
		forever #2 Clk = ~Clk; // 4 ns period.
	end

	initial begin
		reset = 1'b1;
		repeat (resetCycles) @(posedge Clk);
		reset <= 1'b0;
	end

endmodule

// ==== sim/controlFsm_sva.sv ====
`timescale 1ns/1ps

module controlFsm_sva (
	input logic Clk,
	input logic reset,
	input logic instrFetch,
	input logic regWrite,
	input logic dataRead,
	input logic dataWrite
);

	int failures = 0;

	writeExclusive: assert property (@(posedge Clk) disable iff (reset)
		!(regWrite && dataWrite))
		else begin
			failures++;
			$error("register write and data write in the same cycle");
		end

	fetchSpacing: assert property (@(posedge Clk) disable iff (reset)
		instrFetch |=> !instrFetch)
		else begin
			failures++;
			$error("instruction fetch in two consecutive cycles");
		end

	loadCommit: assert property (@(posedge Clk) disable iff (reset)
		dataRead |-> ##2 regWrite) // memWait sits between the read and the write back.
		else begin
			failures++;
			$error("data read not followed by a register write two cycles later");
		end

endmodule

bind controlFsm controlFsm_sva propertyChecks (
	.Clk(Clk),
	.reset(reset),
	.instrFetch(instrFetch),
	.regWrite(regWrite),
	.dataRead(dataRead),
	.dataWrite(dataWrite)
);

// ==== sim/cpuCoreTb.sv ====
`timescale 1ns/1ps

module cpuCoreTb;

	localparam logic [15:0] resetAddr = 16'h3a10;
	localparam int numInstr = 600;
	localparam int waitLimit = 16;
	// register extensions and immediate opcodes share these values, the last slot is ADDUI.
	localparam logic [3:0] aluCodes [8] = '{cpuIsaPkg::extAdd, cpuIsaPkg::extSub,
		cpuIsaPkg::extCmp, cpuIsaPkg::extAnd, cpuIsaPkg::extOr, cpuIsaPkg::extXor,
		cpuIsaPkg::extMul, cpuIsaPkg::opAddui};

	logic Clk;
	logic reset;
	logic [15:0] instr;
	logic [15:0] dataRdata;
	logic instrFetch;
	logic [15:0] instrAddr;
	logic dataRead;
	logic dataWrite;
	logic [15:0] dataAddr;
	logic [15:0] dataWdata;
	logic commitValid;
	logic [3:0] commitReg;
	logic [15:0] commitData;

	logic [15:0] progMem [256];
	logic [15:0] dataMem [256];
	logic [15:0] modelMem [256];
	logic [15:0] modelRegs [16];
	logic [4:0] modelFlags;
	logic [15:0] modelPc;
	logic [31:0] seed;
	logic expCommit;
	logic [3:0] expReg;
	logic [15:0] expData;
	logic expStore;
	logic expLoad;
	logic [15:0] expAddr;
	logic [15:0] expWdata;
	int expCycles;
	int errors [4] = '{0, 0, 0, 0}; // fetch, commit, memory, timing.
	int modelCommits = 0;
	int dutCommits = 0;
	bit timedOut = 1'b0;

	clockGen clocks (.Clk(Clk), .reset(reset));

	cpuCore #(.resetAddr(resetAddr)) dut (.*);

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [15:0] fillWord(input int addr);
		return {addr[7:0] ^ 8'h5a, ~addr[7:0]};
	endfunction

	function automatic logic [15:0] randomInstr(input logic [31:0] r);
		logic [3:0] rd;
		logic [3:0] rs;
		logic [7:0] disp;
		logic [15:0] word;
		rd = r[24:21];
		rs = r[20:17];
		disp = 8'(int'(r[11:9]) - 2);
		if (disp == 8'h00)
			disp = 8'h06;
		if (rd == cpuIsaPkg::condAlways && disp[7])
			disp = -disp; // an unconditional backward hop would never leave its loop.
		case (r[31:28])
			4'd0, 4'd1, 4'd2: begin
				if (r[27:25] == 3'd7)
					word = {cpuIsaPkg::opShift, rd, cpuIsaPkg::extLsh, rs};
				else
					word = {cpuIsaPkg::opRegister, rd, aluCodes[r[27:25]], rs};
			end
			4'd3, 4'd4, 4'd5, 4'd6: word = {aluCodes[r[27:25]], rd, r[16:9]};
			4'd7, 4'd8: word = {cpuIsaPkg::opMemory, rd, cpuIsaPkg::extLoad, rs};
			4'd9: word = {cpuIsaPkg::opMemory, rd, cpuIsaPkg::extStore, rs};
			4'd10, 4'd11: word = {cpuIsaPkg::opMemory, rd, cpuIsaPkg::extScond, rs};
			4'd12, 4'd13: word = {cpuIsaPkg::opBranch, rd, disp};
			4'd14: word = {cpuIsaPkg::opMemory, rd, cpuIsaPkg::extJcond, rs};
			default: word = {r[13], 3'b111, r[24:13]};
		endcase
		return word;
	endfunction

	function automatic int kindOf(input logic [3:0] code);
		for (int i = 0; i < 7; i++)
			if (aluCodes[i] == code)
				return i;
		return -1;
	endfunction

	// kinds follow aluCodes, and 8 is LSH. Returns flags above the result.
	function automatic logic [20:0] aluModel(input int kind, input logic [15:0] a,
		input logic [15:0] b);
		logic [15:0] r;
		logic [4:0] f;
		int s;
		r = '0;
		f = '0;
		case (kind)
			0: begin
				r = a + b;
				s = int'($signed(a)) + int'($signed(b));
				f[cpuIsaPkg::flagC] = (int'(a) + int'(b)) > 65535;
				f[cpuIsaPkg::flagF] = (s > 32767) || (s < -32768);
			end
			1: begin
				r = a - b;
				s = int'($signed(a)) - int'($signed(b));
				f[cpuIsaPkg::flagC] = (a < b);
				f[cpuIsaPkg::flagF] = (s > 32767) || (s < -32768);
			end
			2: begin
				f[cpuIsaPkg::flagZ] = (a == b);
				f[cpuIsaPkg::flagN] = ($signed(a) < $signed(b));
				f[cpuIsaPkg::flagL] = (a < b);
			end
			3: r = a & b;
			4: r = a | b;
			5: r = a ^ b;
			6: r = 16'(32'(a) * 32'(b));
			default: r = a << b[3:0];
		endcase
		if (kind != 2) begin
			f[cpuIsaPkg::flagZ] = (r == 16'h0000);
			f[cpuIsaPkg::flagN] = r[15];
		end
		return {f, r};
	endfunction

	function automatic logic condModel(input logic [3:0] code, input logic [4:0] f);
		logic base;
		case (code[3:1])
			3'd0: base = f[cpuIsaPkg::flagZ];
			3'd1: base = f[cpuIsaPkg::flagC];
			3'd2: base = f[cpuIsaPkg::flagL];
			3'd3: base = f[cpuIsaPkg::flagN];
			3'd4: base = f[cpuIsaPkg::flagF];
			3'd5: base = !(f[cpuIsaPkg::flagL] || f[cpuIsaPkg::flagZ]);
			3'd6: base = !(f[cpuIsaPkg::flagN] || f[cpuIsaPkg::flagZ]);
			default: base = 1'b1;
		endcase
		return base ^ code[0]; // odd codes complement their even partner.
	endfunction

	task automatic stepReference(input logic [15:0] w);
		logic [3:0] rd;
		logic [3:0] rs;
		logic [15:0] operand;
		logic [15:0] nextPc;
		logic [20:0] out;
		int kind;
		rd = w[11:8];
		rs = w[3:0];
		operand = modelRegs[rs];
		nextPc = modelPc + 16'd1;
		kind = -1;
		expCommit = 1'b0;
		expStore = 1'b0;
		expLoad = 1'b0;
		expCycles = 2;
		case (w[15:12])
			cpuIsaPkg::opRegister: kind = kindOf(w[7:4]);
			cpuIsaPkg::opShift: kind = (w[7:4] == cpuIsaPkg::extLsh) ? 8 : -1;
			cpuIsaPkg::opMemory: begin
				if (w[7:4] == cpuIsaPkg::extLoad) begin
					expCycles = 5;
					expCommit = 1'b1;
					expLoad = 1'b1;
					expAddr = modelRegs[rs];
					expData = modelMem[modelRegs[rs][7:0]];
				end else if (w[7:4] == cpuIsaPkg::extStore) begin
					expCycles = 4;
					expStore = 1'b1;
					expAddr = modelRegs[rs];
					expWdata = modelRegs[rd];
					modelMem[expAddr[7:0]] = expWdata;
				end else if (w[7:4] == cpuIsaPkg::extJcond) begin
					expCycles = 3;
					if (condModel(w[11:8], modelFlags))
						nextPc = modelRegs[rs];
				end else if (w[7:4] == cpuIsaPkg::extScond) begin
					expCycles = 3;
					expCommit = 1'b1;
					expData = {15'h0000, condModel(w[3:0], modelFlags)};
				end
			end
			cpuIsaPkg::opBranch: begin
				expCycles = 3;
				if (condModel(w[11:8], modelFlags))
					nextPc = modelPc + {{8{w[7]}}, w[7:0]};
			end
			default: begin
				if (w[15:12] == cpuIsaPkg::opAddui) begin
					kind = 0;
					operand = {8'h00, w[7:0]};
				end else begin
					kind = kindOf(w[15:12]);
					operand = {{8{w[7]}}, w[7:0]};
				end
			end
		endcase
		if (kind >= 0) begin
			out = aluModel(kind, modelRegs[rd], operand);
			modelFlags = out[20:16];
			expCycles = 4;
			expCommit = (kind != 2);
			expData = out[15:0];
		end
		if (expCommit) begin
			expReg = rd;
			modelRegs[rd] = expData;
			modelCommits++;
		end
		modelPc = nextPc;
	endtask

	task automatic checkValue(input string name, input logic [15:0] expected,
		input logic [15:0] actual, input int kind);
		assert (actual === expected) else begin
			errors[kind]++;
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// follows the DUT from one fetch pulse up to the next.
	task automatic runInstr(input logic [15:0] fetchAddr);
		int cycles;
		int commits;
		int stores;
		int reads;
		cycles = 0;
		commits = 0;
		stores = 0;
		reads = 0;
		do begin
			@(posedge Clk);
			cycles++;
			if (commitValid) begin
				commits++;
				dutCommits++;
				if (expCommit) begin
					checkValue("commit register", 16'(expReg), 16'(commitReg), 1);
					checkValue("commit data", expData, commitData, 1);
				end
			end
			if (dataRead) begin
				reads++;
				if (expLoad)
					checkValue("load address", expAddr, dataAddr, 2);
			end
			if (dataWrite) begin
				stores++;
				if (expStore) begin
					checkValue("store address", expAddr, dataAddr, 2);
					checkValue("store data", expWdata, dataWdata, 2);
				end
			end
		end while (!instrFetch && cycles < waitLimit);
		if (!instrFetch) begin
			timedOut = 1'b1;
			$display("no instruction fetch within %0d cycles after the fetch at %h",
				waitLimit, fetchAddr);
		end else begin
			checkValue("commit count", 16'(expCommit), 16'(commits), 1);
			checkValue("load count", 16'(expLoad), 16'(reads), 2);
			checkValue("store count", 16'(expStore), 16'(stores), 2);
			checkValue("instruction cycles", 16'(expCycles), 16'(cycles), 3);
		end
	endtask

	always @(posedge Clk) begin
		if (instrFetch)
			instr <= progMem[instrAddr[7:0]];
		if (dataRead)
			dataRdata <= dataMem[dataAddr[7:0]]; // held until the next read.
		if (dataWrite)
			dataMem[dataAddr[7:0]] <= dataWdata;
	end

	initial begin
		int cycles;
		int total;
		seed = 32'hfadc;
		for (int i = 0; i < 256; i++) begin
			seed = lcgNext(seed);
			progMem[i] = randomInstr(seed);
			dataMem[i] = fillWord(i);
			modelMem[i] = fillWord(i);
		end
		for (int i = 0; i < 16; i++)
			modelRegs[i] = '0;
		modelFlags = '0;
		modelPc = resetAddr;
		instr = '0;
		dataRdata = '0;
		@(posedge Clk);
		cycles = 0;
		while (reset && cycles < waitLimit) begin
			@(posedge Clk);
			cycles++;
		end
		assert (instrFetch) else begin
			errors[3]++;
			$display("no instruction fetch in the first cycle after reset");
		end
		timedOut = !instrFetch;
		for (int n = 0; n < numInstr && !timedOut; n++) begin
			checkValue("fetch address", modelPc, instrAddr, 0);
			stepReference(progMem[modelPc[7:0]]);
			runInstr(instrAddr);
		end
		checkValue("total commits", 16'(modelCommits), 16'(dutCommits), 1);
		total = errors[0] + errors[1] + errors[2] + errors[3]
			+ dut.ctrl.propertyChecks.failures;
		$display("errors: fetch %0d, commit %0d, memory %0d, timing %0d, assertion %0d",
			errors[0], errors[1], errors[2], errors[3], dut.ctrl.propertyChecks.failures);
		if (total == 0 && !timedOut)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// ==== all.f ====
logic/cpuIsaPkg.sv
logic/cpuCtrlPkg.sv
logic/aluUnit.sv
logic/registerFile.sv
logic/programCounter.sv
logic/controlFsm.sv
logic/cpuCore.sv
sim/clockGen.sv
sim/controlFsm_sva.sv
sim/cpuCoreTb.sv

// ==== Bender.yml ====
package:
  name: cpu_core

sources:
  - files:
      - logic/cpuIsaPkg.sv
      - logic/cpuCtrlPkg.sv
      - logic/aluUnit.sv
      - logic/registerFile.sv
      - logic/programCounter.sv
      - logic/controlFsm.sv
      - logic/cpuCore.sv
  - target: simulation
    files:
      - sim/clockGen.sv
      - sim/controlFsm_sva.sv
      - sim/cpuCoreTb.sv
